//--- rtl/cart_pkg.sv
package cart_pkg;

  localparam int addr_w     = 24;
  localparam int io_flags_w = 8;

  // bit positions inside the host feature register
  localparam int feat_msu1 = 3;
  localparam int feat_213f = 4;

  // layout of the i/o event flag vector
  localparam int io_msu     = 0;
  localparam int io_gsu     = 1;
  localparam int io_213f    = 2;
  localparam int io_snescmd = 3;
  localparam int io_nmicmd  = 4;
  localparam int io_retvec  = 5;
  localparam int io_branch1 = 6;
  localparam int io_branch2 = 7;

  typedef enum logic [1:0] {
    tgt_none  = 2'd0,
    tgt_sram0 = 2'd1,
    tgt_sram1 = 2'd2,
    tgt_io    = 2'd3
  } target_t;

  // physical windows inside the sram address space
  localparam logic [addr_w-1:0] saveram_base = 24'hE00000;
  localparam logic [6:0]        gpram_base   = 7'b1100000;

  // snescmd hook locations, matched on the full address
  localparam logic [addr_w-1:0] nmicmd_addr  = 24'h002BF2;
  localparam logic [addr_w-1:0] retvec_addr  = 24'h002A5A;
  localparam logic [addr_w-1:0] branch1_addr = 24'h002A13;
  localparam logic [addr_w-1:0] branch2_addr = 24'h002A4D;

  typedef enum logic [1:0] {
    cfg_feat      = 2'd0,
    cfg_rom_mask  = 2'd1,
    cfg_sram_mask = 2'd2
  } cfg_sel_t;

  localparam int queue_depth = 2; // entries per sram request queue

endpackage

//--- rtl/dec_if.sv
`timescale 1ns/1ps

interface dec_if import cart_pkg::*; ();
  logic                  valid;
  logic                  ready;
  target_t               target;
  logic [addr_w-1:0]     mapped_addr;
  logic [io_flags_w-1:0] io_flags;
  logic                  we;
  logic [7:0]            wdata;

  modport src (
    output valid,
    input  ready,
    output target,
    output mapped_addr,
    output io_flags,
    output we,
    output wdata
  );

  modport dst (
    input  valid,
    output ready,
    input  target,
    input  mapped_addr,
    input  io_flags,
    input  we,
    input  wdata
  );
endinterface

//--- rtl/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if import cart_pkg::*; ();
  logic              valid;
  logic              ready;
  logic [addr_w-1:0] addr;
  logic              we;
  logic [7:0]        wdata;

  // request stream towards one sram port
  modport src (
    output valid,
    input  ready,
    output addr,
    output we,
    output wdata
  );

  modport dst (
    input  valid,
    output ready,
    input  addr,
    input  we,
    input  wdata
  );

endinterface

//--- rtl/cart_cfg_regs.sv
`timescale 1ns/1ps

module cart_cfg_regs import cart_pkg::*; (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              cfg_valid,
  input  cfg_sel_t          cfg_sel,
  input  logic [addr_w-1:0] cfg_data,
  output logic [7:0]        featurebits,
  output logic [addr_w-1:0] rom_mask,
  output logic [addr_w-1:0] saveram_mask
);

  logic wr_feat;
  logic wr_rom;
  logic wr_sram;

  assign wr_feat = cfg_valid && (cfg_sel == cfg_feat);
  assign wr_rom  = cfg_valid && (cfg_sel == cfg_rom_mask);
  assign wr_sram = cfg_valid && (cfg_sel == cfg_sram_mask);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      featurebits <= 8'h00;
    end else if (wr_feat) begin
      featurebits <= cfg_data[7:0]; // upper bits ignored
    end
  end

  // full rom visible until the host narrows it
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      rom_mask <= '1;
    end else if (wr_rom) begin
      rom_mask <= cfg_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      saveram_mask <= '0; // bit 0 clear keeps save ram off
    end else if (wr_sram) begin
      saveram_mask <= cfg_data;
    end
  end

endmodule

//--- rtl/cart_addr_decode.sv
`timescale 1ns/1ps

module cart_addr_decode import cart_pkg::*; (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              bus_valid,
  output logic              bus_ready,
  input  logic [addr_w-1:0] bus_addr,
  input  logic [7:0]        bus_pa,
  input  logic              bus_we,
  input  logic [7:0]        bus_wdata,
  input  logic [7:0]        featurebits,
  input  logic [addr_w-1:0] rom_mask,
  input  logic [addr_w-1:0] saveram_mask,
  dec_if.src                dec
);

  logic                  rom_lo;
  logic                  rom_hi;
  logic                  is_rom;
  logic                  sav_bank;
  logic                  is_saveram;
  logic                  gp_lo;
  logic                  gp_hi;
  logic                  is_gpram;
  logic [addr_w-1:0]     mapped;
  logic [io_flags_w-1:0] flags;
  target_t               tgt;

  // gsu map: rom in 00-3f upper half and 40-5f, ram in 70-71
  assign rom_lo = ~|bus_addr[23:22] & bus_addr[15];
  assign rom_hi = ~bus_addr[23] & bus_addr[22] & ~bus_addr[21];
  assign is_rom = rom_lo | rom_hi;

  // banks 70-71 stay with save ram even while it is disabled
  assign sav_bank   = ~bus_addr[23] & (&bus_addr[22:20]) & ~|bus_addr[19:17];
  assign is_saveram = sav_bank & saveram_mask[0];

  assign gp_lo    = ~|bus_addr[22:20] & (bus_addr[15:13] == 3'b011); // 6000-7fff
  assign gp_hi    = (&bus_addr[22:20]) & ~|bus_addr[19:17] & ~sav_bank;
  assign is_gpram = gp_lo | gp_hi;

  always_comb begin
    if (is_saveram) begin
      mapped = saveram_base | ({7'b0, bus_addr[16:0]} & saveram_mask);
    end else if (rom_lo) begin
      mapped = {3'b000, bus_addr[21:16], bus_addr[14:0]} & rom_mask; // drop a15
    end else if (rom_hi) begin
      mapped = {3'b000, bus_addr[20:0]} & rom_mask;
    end else if (gp_lo) begin
      mapped = {gpram_base, bus_addr[19:16], bus_addr[12:0]};
    end else if (gp_hi) begin
      mapped = {gpram_base, bus_addr[16:0]};
    end else begin
      mapped = bus_addr;
    end
  end

  always_comb begin
    flags = '0;
    flags[io_msu]     = featurebits[feat_msu1] & ~bus_addr[22]
                        & (bus_addr[15:3] == 13'h0400);
    // 3000-32ff, gsu register file and cache
    flags[io_gsu]     = ~bus_addr[22] & (bus_addr[15:10] == 6'b001100)
                        & ~(bus_addr[9] & bus_addr[8]);
    flags[io_213f]    = featurebits[feat_213f] & (bus_pa == 8'h3f);
    flags[io_snescmd] = ~bus_addr[22] & (bus_addr[15:9] == 7'b0010101);
    flags[io_nmicmd]  = (bus_addr == nmicmd_addr);
    flags[io_retvec]  = (bus_addr == retvec_addr);
    flags[io_branch1] = (bus_addr == branch1_addr);
    flags[io_branch2] = (bus_addr == branch2_addr);
  end

  // memory hits win over the i/o windows
  always_comb begin
    if (is_saveram || is_rom) begin
      tgt = tgt_sram0;
    end else if (is_gpram) begin
      tgt = tgt_sram1;
    end else if (|flags) begin
      tgt = tgt_io;
    end else begin
      tgt = tgt_none;
    end
  end

  assign bus_ready = ~dec.valid | dec.ready;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      dec.valid <= 1'b0;
    end else if (bus_ready) begin
      dec.valid <= bus_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (bus_valid && bus_ready) begin
      dec.target      <= tgt;
      dec.mapped_addr <= mapped;
      dec.io_flags    <= flags;
      dec.we          <= bus_we;
      dec.wdata       <= bus_wdata;
    end
  end

endmodule

//--- rtl/cart_access_router.sv
`timescale 1ns/1ps

module cart_access_router import cart_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst_n,
  dec_if.dst                    dec,
  mem_req_if.src                sram0_req,
  mem_req_if.src                sram1_req,
  output logic                  io_valid,
  input  logic                  io_ready,
  output logic [io_flags_w-1:0] io_flags
);

  logic io_free;
  logic io_push;

  assign io_free = ~io_valid | io_ready;

  // only the destination of the current item can stall the decoder
  always_comb begin
    case (dec.target)
      tgt_sram0: dec.ready = sram0_req.ready;
      tgt_sram1: dec.ready = sram1_req.ready;
      tgt_io:    dec.ready = io_free;
      default:   dec.ready = 1'b1; // unmapped, swallowed here
    endcase
  end

  assign sram0_req.valid = dec.valid && (dec.target == tgt_sram0);
  assign sram0_req.addr  = dec.mapped_addr;
  assign sram0_req.we    = dec.we;
  assign sram0_req.wdata = dec.wdata;

  assign sram1_req.valid = dec.valid && (dec.target == tgt_sram1);
  assign sram1_req.addr  = dec.mapped_addr;
  assign sram1_req.we    = dec.we;
  assign sram1_req.wdata = dec.wdata;

  assign io_push = dec.valid && (dec.target == tgt_io) && io_free;

  // single i/o event slot
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      io_valid <= 1'b0;
    end else if (io_push) begin
      io_valid <= 1'b1;
    end else if (io_ready) begin
      io_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (io_push) begin
      io_flags <= dec.io_flags;
    end
  end

endmodule

//--- rtl/sram_req_queue.sv
`timescale 1ns/1ps

module sram_req_queue import cart_pkg::*; (
  input  logic   CLK,
  input  logic   rst_n,
  mem_req_if.dst in_req,
  mem_req_if.src out_req
);

  localparam int ptr_w = $clog2(queue_depth);
  localparam int cnt_w = $clog2(queue_depth + 1);

  logic [addr_w-1:0] addr_mem  [queue_depth];
  logic              we_mem    [queue_depth];
  logic [7:0]        wdata_mem [queue_depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  count;
  logic              push;
  logic              pop;

  assign in_req.ready  = (count != cnt_w'(queue_depth)); // no push when full
  assign out_req.valid = (count != '0);

  assign push = in_req.valid & in_req.ready;
  assign pop  = out_req.valid & out_req.ready;

  assign out_req.addr  = addr_mem[rd_ptr];
  assign out_req.we    = we_mem[rd_ptr];
  assign out_req.wdata = wdata_mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      addr_mem[wr_ptr]  <= in_req.addr;
      we_mem[wr_ptr]    <= in_req.we;
      wdata_mem[wr_ptr] <= in_req.wdata;
    end
  end

endmodule

//--- rtl/cart_map_top.sv
`timescale 1ns/1ps

module cart_map_top import cart_pkg::*; (
  input  logic                  CLK,
  input  logic                  rst_n,
  // snes bus side
  input  logic                  bus_valid,
  output logic                  bus_ready,
  input  logic [addr_w-1:0]     bus_addr,
  input  logic [7:0]            bus_pa,
  input  logic                  bus_we,
  input  logic [7:0]            bus_wdata,
  // host configuration
  input  logic                  cfg_valid,
  input  cfg_sel_t              cfg_sel,
  input  logic [addr_w-1:0]     cfg_data,
  output logic                  sram0_valid,
  input  logic                  sram0_ready,
  output logic [addr_w-1:0]     sram0_addr,
  output logic                  sram0_we,
  output logic [7:0]            sram0_wdata,
  output logic                  sram1_valid,
  input  logic                  sram1_ready,
  output logic [addr_w-1:0]     sram1_addr,
  output logic                  sram1_we,
  output logic [7:0]            sram1_wdata,
  output logic                  io_valid,
  input  logic                  io_ready,
  output logic [io_flags_w-1:0] io_flags
);

  logic [7:0]        featurebits;
  logic [addr_w-1:0] rom_mask;
  logic [addr_w-1:0] saveram_mask;

  dec_if     dec ();
  mem_req_if sram0_in ();
  mem_req_if sram1_in ();
  mem_req_if sram0_out ();
  mem_req_if sram1_out ();

  cart_cfg_regs cfg_regs (
    .CLK, .rst_n, .cfg_valid, .cfg_sel, .cfg_data,
    .featurebits, .rom_mask, .saveram_mask
  );

  cart_addr_decode addr_decode (
    .CLK, .rst_n, .bus_valid, .bus_ready, .bus_addr, .bus_pa, .bus_we, .bus_wdata,
    .featurebits, .rom_mask, .saveram_mask, .dec(dec.src)
  );

  cart_access_router router (
    .CLK, .rst_n, .dec(dec.dst), .sram0_req(sram0_in.src), .sram1_req(sram1_in.src),
    .io_valid, .io_ready, .io_flags
  );

  sram_req_queue sram0_q (.CLK, .rst_n, .in_req(sram0_in.dst), .out_req(sram0_out.src));
  sram_req_queue sram1_q (.CLK, .rst_n, .in_req(sram1_in.dst), .out_req(sram1_out.src));

  assign sram0_valid     = sram0_out.valid;
  assign sram0_out.ready = sram0_ready;
  assign sram0_addr      = sram0_out.addr;
  assign sram0_we        = sram0_out.we;
  assign sram0_wdata     = sram0_out.wdata;

  assign sram1_valid     = sram1_out.valid;
  assign sram1_out.ready = sram1_ready;
  assign sram1_addr      = sram1_out.addr;
  assign sram1_we        = sram1_out.we;
  assign sram1_wdata     = sram1_out.wdata;

endmodule

//--- tb/cart_map_vectors.svh
// columns: phase (0 reset config, 1 host config), bus_addr, bus_pa, bus_we, bus_wdata,
// expected target, expected mapped address, expected io_flags
typedef struct packed {
  logic        phase;
  logic [23:0] addr;
  logic [7:0]  pa;
  logic        we;
  logic [7:0]  wdata;
  target_t     tgt;
  logic [23:0] exp_addr;
  logic [7:0]  exp_flags;
} vec_t;

localparam int num_vec = 28;

function automatic vec_t vec_at(input int idx);
  vec_t v;
  case (idx)
    // rom, a15 dropped in banks 00-3f and linear in 40-5f
    0:  v = {1'b0, 24'h219ABC, 8'h00, 1'b0, 8'h00, tgt_sram0, 24'h109ABC, 8'h00};
    1:  v = {1'b0, 24'h3FFFFF, 8'h00, 1'b0, 8'h00, tgt_sram0, 24'h1FFFFF, 8'h00};
    2:  v = {1'b0, 24'h5F1234, 8'h00, 1'b0, 8'h00, tgt_sram0, 24'h1F1234, 8'h00};
    3:  v = {1'b0, 24'h701234, 8'h00, 1'b1, 8'h5A, tgt_none,  24'h000000, 8'h00};
    4:  v = {1'b0, 24'h006000, 8'h00, 1'b1, 8'hA5, tgt_sram1, 24'hC00000, 8'h00};
    5:  v = {1'b0, 24'h8F6ABC, 8'h00, 1'b0, 8'h00, tgt_sram1, 24'hC1EABC, 8'h00};
    6:  v = {1'b0, 24'hF10010, 8'h00, 1'b1, 8'h3C, tgt_sram1, 24'hC10010, 8'h00};
    7:  v = {1'b0, 24'h003000, 8'h00, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h02};
    8:  v = {1'b0, 24'h002BF2, 8'h00, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h18};
    9:  v = {1'b0, 24'h002A5A, 8'h00, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h28};
    10: v = {1'b0, 24'h002A13, 8'h00, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h48};
    11: v = {1'b0, 24'h002A4D, 8'h00, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h88};
    12: v = {1'b0, 24'h002A00, 8'h00, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h08};
    13: v = {1'b0, 24'h002002, 8'h00, 1'b0, 8'h00, tgt_none,  24'h000000, 8'h00};
    14: v = {1'b0, 24'h00213F, 8'h3F, 1'b0, 8'h00, tgt_none,  24'h000000, 8'h00};
    15: v = {1'b0, 24'h7E1234, 8'h00, 1'b0, 8'h00, tgt_none,  24'h000000, 8'h00};
    16: v = {1'b0, 24'h004000, 8'h00, 1'b0, 8'h00, tgt_none,  24'h000000, 8'h00};
    // masks narrowed, save ram on, msu and 213f enabled
    17: v = {1'b1, 24'h219ABC, 8'h00, 1'b0, 8'h00, tgt_sram0, 24'h009ABC, 8'h00};
    18: v = {1'b1, 24'h5F1234, 8'h00, 1'b0, 8'h00, tgt_sram0, 24'h0F1234, 8'h00};
    19: v = {1'b1, 24'h701234, 8'h00, 1'b1, 8'h5A, tgt_sram0, 24'hE01234, 8'h00};
    20: v = {1'b1, 24'h718ABC, 8'h00, 1'b0, 8'h00, tgt_sram0, 24'hE08ABC, 8'h00};
    21: v = {1'b1, 24'h0F7FFF, 8'h00, 1'b1, 8'hC3, tgt_sram1, 24'hC1FFFF, 8'h00};
    22: v = {1'b1, 24'hF01234, 8'h00, 1'b0, 8'h00, tgt_sram1, 24'hC01234, 8'h00};
    23: v = {1'b1, 24'h002002, 8'h00, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h01};
    24: v = {1'b1, 24'h00213F, 8'h3F, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h04};
    25: v = {1'b1, 24'h2032FF, 8'h00, 1'b0, 8'h00, tgt_io,    24'h000000, 8'h02};
    26: v = {1'b1, 24'h003300, 8'h00, 1'b0, 8'h00, tgt_none,  24'h000000, 8'h00};
    27: v = {1'b1, 24'h700001, 8'h3F, 1'b0, 8'h00, tgt_sram0, 24'hE00001, 8'h00}; // ram beats 213f
    default: v = '0;
  endcase
  return v;
endfunction

//--- tb/tb_cart_map.sv
`timescale 1ns/1ps

module tb_cart_map import cart_pkg::*; ();

  `include "cart_map_vectors.svh"

  localparam int cycle_limit = num_vec * 20 + 200;
  localparam int drain_limit = (queue_depth + 2) * 20;

  logic CLK, rst_n;
  logic bus_valid, bus_ready, bus_we;
  logic [23:0] bus_addr;
  logic [7:0] bus_pa, bus_wdata;
  logic cfg_valid;
  cfg_sel_t cfg_sel;
  logic [23:0] cfg_data;
  logic sram0_valid, sram0_ready, sram0_we;
  logic sram1_valid, sram1_ready, sram1_we;
  logic [23:0] sram0_addr, sram1_addr;
  logic [7:0] sram0_wdata, sram1_wdata, io_flags;
  logic io_valid, io_ready;
  logic [31:0] lcg_state;
  int cycles;
  int drain_cycles;
  logic [32:0] exp_sram0[$]; // {addr, we, wdata}
  logic [32:0] exp_sram1[$];
  logic [7:0] exp_io[$];

  cart_map_top dut0 (.*);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic expect_result(input vec_t v);
    case (v.tgt)
      tgt_sram0: exp_sram0.push_back({v.exp_addr, v.we, v.wdata});
      tgt_sram1: exp_sram1.push_back({v.exp_addr, v.we, v.wdata});
      tgt_io:    exp_io.push_back(v.exp_flags);
      default:   ; // dropped by the DUT
    endcase
  endtask

  task automatic send_access(input vec_t v);
    logic taken;
    bus_valid = 1'b1;
    bus_addr  = v.addr;
    bus_pa    = v.pa;
    bus_we    = v.we;
    bus_wdata = v.wdata;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge CLK);
      taken = bus_ready; // transfer happens on the coming edge
      if (taken) expect_result(v);
      @(posedge CLK);
      #1;
    end
    bus_valid = 1'b0;
  endtask

  task automatic run_phase(input logic phase);
    vec_t v;
    for (int i = 0; i < num_vec; i++) begin
      v = vec_at(i);
      if (v.phase == phase) send_access(v);
    end
  endtask

  task automatic write_cfg(input cfg_sel_t sel, input logic [23:0] data);
    cfg_valid = 1'b1;
    cfg_sel   = sel;
    cfg_data  = data;
    @(posedge CLK);
    #1;
    cfg_valid = 1'b0;
  endtask

  task automatic check_sram(input int port, input logic [23:0] addr, input logic we,
                            input logic [7:0] wdata);
    logic [32:0] e;
    if (port == 0) begin
      assert (exp_sram0.size() > 0) else fail_now("unexpected request on sram0");
      e = exp_sram0.pop_front();
    end else begin
      assert (exp_sram1.size() > 0) else fail_now("unexpected request on sram1");
      e = exp_sram1.pop_front();
    end
    assert (addr == e[32:9])
      else fail_now($sformatf("mismatch sram%0d_addr exp %h got %h", port, e[32:9], addr));
    assert (we == e[8])
      else fail_now($sformatf("mismatch sram%0d_we exp %h got %h", port, e[8], we));
    assert (wdata == e[7:0])
      else fail_now($sformatf("mismatch sram%0d_wdata exp %h got %h", port, e[7:0], wdata));
  endtask

  task automatic check_io(input logic [7:0] flags);
    logic [7:0] e;
    assert (exp_io.size() > 0) else fail_now("unexpected event on the io port");
    e = exp_io.pop_front();
    assert (flags == e) else fail_now($sformatf("mismatch io_flags exp %h got %h", e, flags));
  endtask

  // outputs are settled half a cycle after the inputs change
  always @(negedge CLK) begin
    if (rst_n && sram0_valid && sram0_ready) check_sram(0, sram0_addr, sram0_we, sram0_wdata);
    if (rst_n && sram1_valid && sram1_ready) check_sram(1, sram1_addr, sram1_we, sram1_wdata);
    if (rst_n && io_valid && io_ready) check_io(io_flags);
  end

  initial begin
    lcg_state = 32'h4129ce42;
    forever begin
      @(posedge CLK);
      #1;
      lcg_state   = lcg_next(lcg_state);
      sram0_ready = lcg_state[31];
      io_ready    = lcg_state[29];
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > cycle_limit) fail_now($sformatf("timeout after %0d cycles", cycles));
  end

  initial begin
    cycles       = 0;
    drain_cycles = 0;
    rst_n        = 1'b0;
    bus_valid    = 1'b0;
    bus_addr     = '0;
    bus_pa       = '0;
    bus_we       = 1'b0;
    bus_wdata    = '0;
    cfg_valid    = 1'b0;
    cfg_sel      = cfg_feat;
    cfg_data     = '0;
    sram0_ready  = 1'b0;
    sram1_ready  = 1'b1;
    io_ready     = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    run_phase(1'b0);
    write_cfg(cfg_feat, 24'((1 << feat_msu1) | (1 << feat_213f)));
    write_cfg(cfg_rom_mask, 24'h0FFFFF); // 1 MB rom image so the upper half folds
    write_cfg(cfg_sram_mask, 24'h00FFFF);
    run_phase(1'b1);
    while ((exp_sram0.size() != 0 || exp_sram1.size() != 0 || exp_io.size() != 0)
           && drain_cycles < drain_limit) begin
      @(posedge CLK);
      drain_cycles++;
    end
    repeat (4) @(posedge CLK); // a stray output would surface within the pipeline latency
    if (exp_sram0.size() == 0 && exp_sram1.size() == 0 && exp_io.size() == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      fail_now("expected outputs still pending at end of run");
    end
  end

endmodule

//--- flist.f
+incdir+tb
rtl/cart_pkg.sv
rtl/dec_if.sv
rtl/mem_req_if.sv
rtl/cart_cfg_regs.sv
rtl/cart_addr_decode.sv
rtl/cart_access_router.sv
rtl/sram_req_queue.sv
rtl/cart_map_top.sv
tb/tb_cart_map.sv

//--- Bender.yml
package:
  name: cart_map

sources:
  - rtl/cart_pkg.sv
  - rtl/dec_if.sv
  - rtl/mem_req_if.sv
  - rtl/cart_cfg_regs.sv
  - rtl/cart_addr_decode.sv
  - rtl/cart_access_router.sv
  - rtl/sram_req_queue.sv
  - rtl/cart_map_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_cart_map.sv
